//--- hw/ooo_pkg.sv
`default_nettype none

package ooo_pkg;

	//////////////////////////////////////////////////
	// widths

	parameter int XLEN      = 32;
	parameter int REG_IDX_W = 5;
	parameter int NUM_REGS  = 32;
	// widest tag any struct carries, ROB_DEPTH up to 16
	parameter int TAG_W_MAX = 4;

	//////////////////////////////////////////////////
	// encodings

	parameter logic [6:0]  OPC_OP        = 7'b0110011;
	parameter logic [6:0]  OPC_OP_IMM    = 7'b0010011;
	parameter logic [6:0]  FUNCT7_SUB    = 7'b0100000;
	parameter logic [6:0]  FUNCT7_MULDIV = 7'b0000001;
	parameter logic [31:0] WFI_WORD      = 32'h10500073;

	// register-register view
	typedef struct packed {
		logic [6:0]           funct7;
		logic [REG_IDX_W-1:0] rs2;
		logic [REG_IDX_W-1:0] rs1;
		logic [2:0]           funct3;
		logic [REG_IDX_W-1:0] rd;
		logic [6:0]           opcode;
	} r_type_s;

	// register-immediate view
	typedef struct packed {
		logic [11:0]          imm;
		logic [REG_IDX_W-1:0] rs1;
		logic [2:0]           funct3;
		logic [REG_IDX_W-1:0] rd;
		logic [6:0]           opcode;
	} i_type_s;

	// one fetched word, two decodes
	typedef union packed {
		r_type_s r;
		i_type_s i;
	} inst_word_u;

	typedef enum logic [2:0] {
		OP_ADD = 3'd0,
		OP_SUB = 3'd1,
		OP_MUL = 3'd2,
		OP_NOP = 3'd3,
		OP_WFI = 3'd4
	} op_kind_e;

	//////////////////////////////////////////////////
	// inter-stage packets

	// issue to execute
	typedef struct packed {
		logic                 valid;
		logic [TAG_W_MAX-1:0] tag;
		op_kind_e             op;
		logic [XLEN-1:0]      a;
		logic [XLEN-1:0]      b;
	} dispatch_s;

	// execute to reorder buffer
	typedef struct packed {
		logic                 valid;
		logic [TAG_W_MAX-1:0] tag;
		logic [XLEN-1:0]      value;
	} result_s;

	// one reorder buffer slot
	typedef struct packed {
		logic                 valid;
		logic                 done;
		logic [REG_IDX_W-1:0] rd;
		logic                 wr_en;
		logic                 halt;
		logic [XLEN-1:0]      value;
		logic [XLEN-1:0]      npc;
	} rob_entry_s;

	// commit to register file
	typedef struct packed {
		logic                 valid;
		logic [REG_IDX_W-1:0] rd;
		logic                 wr_en;
		logic [XLEN-1:0]      value;
	} retire_s;

endpackage

`default_nettype wire

//--- hw/issue_stage.sv
`default_nettype none
`timescale 1ns/1ns

module issue_stage #(
	parameter int ROB_DEPTH = 8,
	localparam int TAG_W = $clog2(ROB_DEPTH)
) (
	input  logic                        clock,
	input  logic                        reset,
	input  logic                        inst_valid,
	input  ooo_pkg::inst_word_u         inst,
	input  logic                        full,
	input  logic [TAG_W-1:0]            alloc_tag,
	input  logic                        rs1_done,
	input  logic [ooo_pkg::XLEN-1:0]    rs1_value,
	input  logic                        rs2_done,
	input  logic [ooo_pkg::XLEN-1:0]    rs2_value,
	input  ooo_pkg::retire_s            writeback,
	input  logic [TAG_W-1:0]            retire_tag,
	input  logic                        halted,
	output logic                        stall,
	output logic                        alloc,
	output ooo_pkg::rob_entry_s         alloc_entry,
	output logic [TAG_W-1:0]            rs1_tag,
	output logic [TAG_W-1:0]            rs2_tag,
	output ooo_pkg::dispatch_s          dispatch
);

	logic [ooo_pkg::XLEN-1:0] regs [ooo_pkg::NUM_REGS];
	logic [ooo_pkg::NUM_REGS-1:0] map_busy;
	logic [TAG_W-1:0] map_tag [ooo_pkg::NUM_REGS];
	logic [ooo_pkg::XLEN-1:0] pc;

	logic is_op, is_add, is_sub, is_mul, is_addi, is_wfi;
	logic uses_rs1, uses_rs2, map_wr;
	logic [ooo_pkg::REG_IDX_W-1:0] rs1, rs2, rd;
	logic [ooo_pkg::XLEN-1:0] imm_ext, operand_a, operand_b;
	ooo_pkg::op_kind_e op;
	logic accept;

	//////////////////////////////////////////////////
	// decode

	// R view for ADD/SUB/MUL
	assign is_op   = inst.r.opcode == ooo_pkg::OPC_OP && inst.r.funct3 == 3'b000;
	assign is_add  = is_op && inst.r.funct7 == 7'b0000000;
	assign is_sub  = is_op && inst.r.funct7 == ooo_pkg::FUNCT7_SUB;
	assign is_mul  = is_op && inst.r.funct7 == ooo_pkg::FUNCT7_MULDIV;
	// I view for ADDI
	assign is_addi = inst.i.opcode == ooo_pkg::OPC_OP_IMM && inst.i.funct3 == 3'b000;
	assign is_wfi  = inst == ooo_pkg::WFI_WORD;
	assign imm_ext = {{(ooo_pkg::XLEN-12){inst.i.imm[11]}}, inst.i.imm};

	assign rs1 = inst.r.rs1;
	assign rs2 = inst.r.rs2;
	assign rd  = inst.r.rd;

	always_comb begin
		op = ooo_pkg::OP_NOP;
		if (is_add || is_addi)
			op = ooo_pkg::OP_ADD;
		else if (is_sub)
			op = ooo_pkg::OP_SUB;
		else if (is_mul)
			op = ooo_pkg::OP_MUL;
		else if (is_wfi)
			op = ooo_pkg::OP_WFI;
	end

	// every supported arith op reads rs1 and writes rd
	assign uses_rs1 = is_add || is_sub || is_mul || is_addi;
	assign uses_rs2 = is_add || is_sub || is_mul;

	//////////////////////////////////////////////////
	// operands and stall

	assign rs1_tag = map_tag[rs1];
	assign rs2_tag = map_tag[rs2];

	// x0 first, then in-flight value, then arch file
	assign operand_a = (rs1 == '0) ? '0 : map_busy[rs1] ? rs1_value : regs[rs1];
	assign operand_b = is_addi ? imm_ext :
		(rs2 == '0) ? '0 : map_busy[rs2] ? rs2_value : regs[rs2];

	assign stall = halted || full || (inst_valid &&
		((uses_rs1 && map_busy[rs1] && !rs1_done) ||
		 (uses_rs2 && map_busy[rs2] && !rs2_done)));
	assign accept = inst_valid && !stall;
	assign map_wr = accept && uses_rs1 && rd != '0;

	// nop and wfi go in already done
	assign alloc = accept;
	always_comb begin
		alloc_entry.valid = 1'b1;
		alloc_entry.done  = !uses_rs1;
		alloc_entry.rd    = rd;
		alloc_entry.wr_en = uses_rs1 && rd != '0;
		alloc_entry.halt  = is_wfi;
		alloc_entry.value = '0;
		alloc_entry.npc   = pc + ooo_pkg::XLEN'(4);
	end

	//////////////////////////////////////////////////
	// state

	// arch regs, written only at retire
	always_ff @(posedge clock) begin
		if (reset) begin
			for (int i = 0; i < ooo_pkg::NUM_REGS; i++)
				regs[i] <= '0;
		end else if (writeback.valid && writeback.wr_en) begin
			regs[writeback.rd] <= writeback.value;
		end
	end

	// busy clears only if the retiring tag is still the newest producer
	always_ff @(posedge clock) begin
		if (reset) begin
			map_busy <= '0;
		end else begin
			if (writeback.valid && writeback.wr_en && map_tag[writeback.rd] == retire_tag)
				map_busy[writeback.rd] <= 1'b0;
			// a new mapping beats the clear
			if (map_wr)
				map_busy[rd] <= 1'b1;
		end
	end

	always_ff @(posedge clock) begin
		if (map_wr)
			map_tag[rd] <= alloc_tag;
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			pc <= '0;
			dispatch.valid <= 1'b0;
		end else begin
			if (accept)
				pc <= pc + ooo_pkg::XLEN'(4);
			dispatch.valid <= accept && uses_rs1;
			dispatch.tag   <= ooo_pkg::TAG_W_MAX'(alloc_tag);
			dispatch.op    <= op;
			dispatch.a     <= operand_a;
			dispatch.b     <= operand_b;
		end
	end

endmodule

`default_nettype wire

//--- hw/execute_unit.sv
`default_nettype none
`timescale 1ns/1ns

module execute_unit #(
	parameter int ROB_DEPTH = 8,
	parameter int MULT_STAGES = 3
) (
	input  logic               clock,
	input  logic               reset,
	input  ooo_pkg::dispatch_s dispatch,
	output ooo_pkg::result_s   alu_result,
	output ooo_pkg::result_s   mult_result
);

	localparam int TAG_W = $clog2(ROB_DEPTH);
	// multiplier bits of b consumed per stage
	localparam int CHUNK_W = (ooo_pkg::XLEN + MULT_STAGES - 1) / MULT_STAGES;

	typedef struct packed {
		logic                     valid;
		logic [TAG_W-1:0]         tag;
		logic [ooo_pkg::XLEN-1:0] a;
		logic [ooo_pkg::XLEN-1:0] b;
		logic [ooo_pkg::XLEN-1:0] acc;
	} mult_stage_s;

	mult_stage_s mult_in;
	mult_stage_s pipe_q [MULT_STAGES-1];

	//////////////////////////////////////////////////
	// alu

	// dispatch reg is the one cycle of latency
	always_comb begin
		alu_result.valid = dispatch.valid &&
			(dispatch.op == ooo_pkg::OP_ADD || dispatch.op == ooo_pkg::OP_SUB);
		alu_result.tag   = dispatch.tag;
		alu_result.value = (dispatch.op == ooo_pkg::OP_SUB) ?
			dispatch.a - dispatch.b : dispatch.a + dispatch.b;
	end

	//////////////////////////////////////////////////
	// multiplier

	always_comb begin
		mult_in.valid = dispatch.valid && dispatch.op == ooo_pkg::OP_MUL;
		mult_in.tag   = dispatch.tag[TAG_W-1:0];
		mult_in.a     = dispatch.a;
		mult_in.b     = dispatch.b;
		mult_in.acc   = '0;
	end

	// each stage adds a * one slice of b, shifted into place
	for (genvar i = 0; i < MULT_STAGES; i++) begin : g_mult
		mult_stage_s              cur;
		logic [CHUNK_W-1:0]       chunk;
		logic [ooo_pkg::XLEN-1:0] sum;

		if (i == 0) begin : g_first
			assign cur = mult_in;
		end else begin : g_rest
			assign cur = pipe_q[i-1];
		end

		assign chunk = CHUNK_W'(cur.b >> (i * CHUNK_W));
		// low XLEN bits only
		assign sum = cur.acc + (ooo_pkg::XLEN'(cur.a * chunk) << (i * CHUNK_W));

		if (i < MULT_STAGES - 1) begin : g_reg
			always_ff @(posedge clock) begin
				if (reset) begin
					pipe_q[i].valid <= 1'b0;
				end else begin
					pipe_q[i].valid <= cur.valid;
					pipe_q[i].tag   <= cur.tag;
					pipe_q[i].a     <= cur.a;
					pipe_q[i].b     <= cur.b;
					pipe_q[i].acc   <= sum;
				end
			end
		end else begin : g_out
			// last slice lands straight in the buffer
			always_comb begin
				mult_result.valid = cur.valid;
				mult_result.tag   = ooo_pkg::TAG_W_MAX'(cur.tag);
				mult_result.value = sum;
			end
		end
	end

endmodule

`default_nettype wire

//--- hw/reorder_buffer.sv
`default_nettype none
`timescale 1ns/1ns

module reorder_buffer #(
	parameter int ROB_DEPTH = 8,
	localparam int TAG_W = $clog2(ROB_DEPTH)
) (
	input  logic                     clock,
	input  logic                     reset,
	input  logic                     alloc,
	input  ooo_pkg::rob_entry_s      alloc_entry,
	input  ooo_pkg::result_s         alu_result,
	input  ooo_pkg::result_s         mult_result,
	input  logic [TAG_W-1:0]         rs1_tag,
	input  logic [TAG_W-1:0]         rs2_tag,
	input  logic                     retire,
	output logic                     full,
	output logic [TAG_W-1:0]         alloc_tag,
	output logic                     rs1_done,
	output logic [ooo_pkg::XLEN-1:0] rs1_value,
	output logic                     rs2_done,
	output logic [ooo_pkg::XLEN-1:0] rs2_value,
	output ooo_pkg::rob_entry_s      head,
	output logic [TAG_W-1:0]         retire_tag
);

	ooo_pkg::rob_entry_s entries [ROB_DEPTH];
	logic [TAG_W-1:0] head_ptr;
	logic [TAG_W-1:0] tail_ptr;
	// one wider than a tag so full fits
	logic [TAG_W:0] count;
	logic [TAG_W-1:0] alu_idx;
	logic [TAG_W-1:0] mult_idx;

	// wrap at ROB_DEPTH, not at a power of two
	function automatic logic [TAG_W-1:0] next_ptr(input logic [TAG_W-1:0] ptr);
		return (ptr == TAG_W'(ROB_DEPTH - 1)) ? '0 : ptr + 1'b1;
	endfunction

	assign alu_idx  = alu_result.tag[TAG_W-1:0];
	assign mult_idx = mult_result.tag[TAG_W-1:0];

	//////////////////////////////////////////////////
	// status and tag reads

	assign full       = count == (TAG_W+1)'(ROB_DEPTH);
	assign alloc_tag  = tail_ptr;
	assign retire_tag = head_ptr;

	// issue only trusts these for mapped sources
	assign rs1_done  = entries[rs1_tag].done;
	assign rs1_value = entries[rs1_tag].value;
	assign rs2_done  = entries[rs2_tag].done;
	assign rs2_value = entries[rs2_tag].value;

	// head offered only once its result is in
	always_comb begin
		head       = entries[head_ptr];
		head.valid = entries[head_ptr].valid && entries[head_ptr].done;
	end

	//////////////////////////////////////////////////
	// slots

	always_ff @(posedge clock) begin
		if (reset) begin
			for (int i = 0; i < ROB_DEPTH; i++)
				entries[i].valid <= 1'b0;
		end else begin
			// commit has already seen the head done
			if (retire)
				entries[head_ptr].valid <= 1'b0;
			if (alloc)
				entries[tail_ptr] <= alloc_entry;
			// both units may finish together, different tags
			if (alu_result.valid) begin
				entries[alu_idx].done  <= 1'b1;
				entries[alu_idx].value <= alu_result.value;
			end
			if (mult_result.valid) begin
				entries[mult_idx].done  <= 1'b1;
				entries[mult_idx].value <= mult_result.value;
			end
		end
	end

	//////////////////////////////////////////////////
	// pointers

	always_ff @(posedge clock) begin
		if (reset) begin
			head_ptr <= '0;
			tail_ptr <= '0;
			count    <= '0;
		end else begin
			if (retire)
				head_ptr <= next_ptr(head_ptr);
			if (alloc)
				tail_ptr <= next_ptr(tail_ptr);
			// push and pop in one cycle leave count alone
			case ({alloc, retire})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

endmodule

`default_nettype wire

//--- hw/commit_stage.sv
`default_nettype none
`timescale 1ns/1ns

module commit_stage (
	input  logic                          clock,
	input  logic                          reset,
	input  ooo_pkg::rob_entry_s           head,
	output logic                          retire,
	output ooo_pkg::retire_s              writeback,
	output logic                          halted,
	output logic                          commit_valid,
	output logic [ooo_pkg::REG_IDX_W-1:0] commit_rd,
	output logic                          commit_wr_en,
	output logic [ooo_pkg::XLEN-1:0]      commit_data,
	output logic [ooo_pkg::XLEN-1:0]      commit_npc
);

	// one per cycle, frozen after wfi
	assign retire = head.valid && !halted;

	// arch file write, same edge as the pop
	always_comb begin
		writeback.valid = retire;
		writeback.rd    = head.rd;
		writeback.wr_en = head.wr_en;
		writeback.value = head.value;
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			commit_valid <= 1'b0;
			commit_wr_en <= 1'b0;
			halted       <= 1'b0;
		end else begin
			commit_valid <= retire;
			commit_wr_en <= retire && head.wr_en;
			// sticky until reset
			if (retire && head.halt)
				halted <= 1'b1;
		end
	end

	// payload follows the strobe
	always_ff @(posedge clock) begin
		if (retire) begin
			commit_rd   <= head.rd;
			commit_data <= head.value;
			commit_npc  <= head.npc;
		end
	end

endmodule

`default_nettype wire

//--- hw/ooo_core.sv
`default_nettype none
`timescale 1ns/1ns

module ooo_core #(
	parameter int ROB_DEPTH = 8,
	parameter int MULT_STAGES = 3
) (
	input  logic                          clock,
	input  logic                          reset,
	input  logic                          inst_valid,
	input  ooo_pkg::inst_word_u           inst,
	output logic                          stall,
	output logic                          commit_valid,
	output logic [ooo_pkg::REG_IDX_W-1:0] commit_rd,
	output logic                          commit_wr_en,
	output logic [ooo_pkg::XLEN-1:0]      commit_data,
	output logic [ooo_pkg::XLEN-1:0]      commit_npc,
	output logic                          halted
);

	localparam int TAG_W = $clog2(ROB_DEPTH);

	//////////////////////////////////////////////////
	// interconnect

	// issue <-> buffer
	logic alloc, full;
	ooo_pkg::rob_entry_s alloc_entry;
	logic [TAG_W-1:0] alloc_tag, rs1_tag, rs2_tag;
	logic rs1_done, rs2_done;
	logic [ooo_pkg::XLEN-1:0] rs1_value, rs2_value;
	// execute
	ooo_pkg::dispatch_s dispatch;
	ooo_pkg::result_s alu_result, mult_result;
	// commit loop
	ooo_pkg::rob_entry_s head;
	logic retire;
	logic [TAG_W-1:0] retire_tag;
	ooo_pkg::retire_s writeback;

	issue_stage #(.ROB_DEPTH(ROB_DEPTH)) issue_stage_inst (
		.clock(clock), .reset(reset), .inst_valid(inst_valid), .inst(inst),
		.full(full), .alloc_tag(alloc_tag),
		.rs1_done(rs1_done), .rs1_value(rs1_value),
		.rs2_done(rs2_done), .rs2_value(rs2_value),
		.writeback(writeback), .retire_tag(retire_tag), .halted(halted),
		.stall(stall), .alloc(alloc), .alloc_entry(alloc_entry),
		.rs1_tag(rs1_tag), .rs2_tag(rs2_tag), .dispatch(dispatch)
	);

	execute_unit #(.ROB_DEPTH(ROB_DEPTH), .MULT_STAGES(MULT_STAGES)) execute_unit_inst (
		.clock(clock), .reset(reset), .dispatch(dispatch),
		.alu_result(alu_result), .mult_result(mult_result)
	);

	reorder_buffer #(.ROB_DEPTH(ROB_DEPTH)) reorder_buffer_inst (
		.clock(clock), .reset(reset), .alloc(alloc), .alloc_entry(alloc_entry),
		.alu_result(alu_result), .mult_result(mult_result),
		.rs1_tag(rs1_tag), .rs2_tag(rs2_tag), .retire(retire),
		.full(full), .alloc_tag(alloc_tag),
		.rs1_done(rs1_done), .rs1_value(rs1_value),
		.rs2_done(rs2_done), .rs2_value(rs2_value),
		.head(head), .retire_tag(retire_tag)
	);

	commit_stage commit_stage_inst (
		.clock(clock), .reset(reset), .head(head),
		.retire(retire), .writeback(writeback), .halted(halted),
		.commit_valid(commit_valid), .commit_rd(commit_rd), .commit_wr_en(commit_wr_en),
		.commit_data(commit_data), .commit_npc(commit_npc)
	);

endmodule

`default_nettype wire

//--- testbench/tb_clock_gen.sv
`default_nettype none
`timescale 1ns/1ns

module tb_clock_gen #(
	parameter int PERIOD = 4,
	parameter int RESET_CYCLES = 10
) (
	output logic clock,
	output logic reset
);

	initial clock = 1'b0;
	always #(PERIOD / 2) clock = ~clock;

	// release on a falling edge, clear of the sampling edge
	initial begin
		reset = 1'b1;
		repeat (RESET_CYCLES) @(negedge clock);
		reset = 1'b0;
	end

endmodule

`default_nettype wire

//--- testbench/ooo_core_sva.sv
`default_nettype none
`timescale 1ns/1ns

module ooo_core_sva (
	input logic                          clock,
	input logic                          reset,
	input logic                          stall,
	input logic                          commit_valid,
	input logic [ooo_pkg::REG_IDX_W-1:0] commit_rd,
	input logic                          commit_wr_en,
	input logic                          halted
);

	// wfi commit is the last one
	a_no_commit_after_halt: assert property (@(posedge clock) disable iff (reset)
		$past(halted) |-> !commit_valid) else $error("commit while already halted");

	// halt is sticky and holds the source off
	a_halt_sticky: assert property (@(posedge clock) disable iff (reset)
		halted |=> halted) else $error("halted dropped");
	a_stall_when_halted: assert property (@(posedge clock) disable iff (reset)
		halted |-> stall) else $error("stall low while halted");

	// x0 is never a destination
	a_no_x0_write: assert property (@(posedge clock) disable iff (reset)
		commit_wr_en |-> commit_rd != '0) else $error("register write to x0");

	// first cycle out of reset is quiet
	a_quiet_after_reset: assert property (@(posedge clock)
		$fell(reset) |-> !commit_valid && !halted && !stall)
		else $error("outputs active after reset");

endmodule

bind ooo_core ooo_core_sva ooo_core_sva_inst (
	.clock(clock), .reset(reset), .stall(stall), .commit_valid(commit_valid),
	.commit_rd(commit_rd), .commit_wr_en(commit_wr_en), .halted(halted)
);

`default_nettype wire

//--- testbench/ooo_core_tb.sv
`default_nettype none
`timescale 1ns/1ns

module ooo_core_tb;

	localparam int TAB_LEN = 50;
	localparam int CYCLE_LIMIT = 40 * TAB_LEN + 100;
	localparam int HOLD_CYCLES = 25;
	localparam logic [31:0] SEED = 32'd13955;

	// one row per instruction with its idle gap and expected commit
	typedef struct packed {
		ooo_pkg::inst_word_u word;
		logic [3:0]          gap;
		ooo_pkg::retire_s    exp;
	} stim_s;

	logic clock, reset, inst_valid;
	ooo_pkg::inst_word_u inst;
	logic stall, commit_valid, commit_wr_en, halted;
	logic [ooo_pkg::REG_IDX_W-1:0] commit_rd;
	logic [ooo_pkg::XLEN-1:0] commit_data, commit_npc;

	stim_s tab [TAB_LEN];
	logic [31:0] model_regs [32];
	logic [31:0] rng;
	int n_entries = 0;
	int n_commits = 0;
	int commit_count = 0;
	int cycle_count = 0;
	int burst_lo = 0;
	int burst_hi = 0;
	logic saw_burst_stall = 1'b0;

	tb_clock_gen #(.PERIOD(4), .RESET_CYCLES(10)) tb_clock_gen_inst (
		.clock(clock), .reset(reset)
	);

	ooo_core ooo_core_inst (
		.clock(clock), .reset(reset), .inst_valid(inst_valid), .inst(inst),
		.stall(stall), .commit_valid(commit_valid), .commit_rd(commit_rd),
		.commit_wr_en(commit_wr_en), .commit_data(commit_data),
		.commit_npc(commit_npc), .halted(halted)
	);

	//////////////////////////////////////////////////
	// random draws and encoding

	function automatic logic [31:0] xorshift_next();
		logic [31:0] x;
		x = rng;
		x ^= x << 13;
		x ^= x >> 17;
		x ^= x << 5;
		rng = x;
		return x;
	endfunction

	function automatic logic [4:0] pick_reg(input int lo, input int span);
		return 5'(lo + int'(xorshift_next() % 32'(span)));
	endfunction

	function automatic logic [3:0] rand_gap();
		return 4'(xorshift_next() % 32'd3);
	endfunction

	function automatic ooo_pkg::inst_word_u enc_r(input logic [6:0] f7,
			input logic [4:0] rd, input logic [4:0] rs1, input logic [4:0] rs2);
		ooo_pkg::inst_word_u w;
		w.r.funct7 = f7;
		w.r.rs2    = rs2;
		w.r.rs1    = rs1;
		w.r.funct3 = 3'b000;
		w.r.rd     = rd;
		w.r.opcode = ooo_pkg::OPC_OP;
		return w;
	endfunction

	//////////////////////////////////////////////////
	// reference model in program order

	task automatic push_entry(input ooo_pkg::inst_word_u word, input logic [3:0] gap,
			input logic [4:0] rd, input logic [31:0] value, input logic writes);
		tab[n_entries].word      = word;
		tab[n_entries].gap       = gap;
		tab[n_entries].exp.valid = 1'b1;
		tab[n_entries].exp.rd    = rd;
		// x0 stays zero
		tab[n_entries].exp.wr_en = writes && rd != 5'd0;
		tab[n_entries].exp.value = value;
		if (writes && rd != 5'd0)
			model_regs[rd] = value;
		n_entries++;
	endtask

	task automatic add_arith(input ooo_pkg::op_kind_e kind, input logic [4:0] rd,
			input logic [4:0] rs1, input logic [4:0] rs2, input logic [3:0] gap);
		logic [31:0] a, b, res;
		logic [6:0] f7;
		a = model_regs[rs1];
		b = model_regs[rs2];
		// wrapping arithmetic and the low word of the product
		if (kind == ooo_pkg::OP_SUB) begin
			res = a - b;
			f7 = ooo_pkg::FUNCT7_SUB;
		end else if (kind == ooo_pkg::OP_MUL) begin
			res = a * b;
			f7 = ooo_pkg::FUNCT7_MULDIV;
		end else begin
			res = a + b;
			f7 = 7'b0000000;
		end
		push_entry(enc_r(f7, rd, rs1, rs2), gap, rd, res, 1'b1);
	endtask

	task automatic add_addi(input logic [4:0] rd, input logic [4:0] rs1,
			input logic [11:0] imm, input logic [3:0] gap);
		ooo_pkg::inst_word_u w;
		w.i.imm    = imm;
		w.i.rs1    = rs1;
		w.i.funct3 = 3'b000;
		w.i.rd     = rd;
		w.i.opcode = ooo_pkg::OPC_OP_IMM;
		push_entry(w, gap, rd, model_regs[rs1] + {{20{imm[11]}}, imm}, 1'b1);
	endtask

	task automatic build_table();
		ooo_pkg::inst_word_u w;
		logic [4:0] src;
		for (int r = 0; r < 32; r++)
			model_regs[r] = '0;
		// seed x1..x8 off x0
		for (int k = 1; k <= 8; k++)
			add_addi(5'(k), 5'd0, 12'(xorshift_next()), rand_gap());
		// independent add and sub
		for (int k = 0; k < 6; k++) begin
			if (k % 2 == 1)
				add_arith(ooo_pkg::OP_SUB, pick_reg(9, 7), pick_reg(0, 9), pick_reg(0, 9),
					rand_gap());
			else
				add_arith(ooo_pkg::OP_ADD, pick_reg(9, 7), pick_reg(0, 9), pick_reg(0, 9),
					rand_gap());
		end
		// squares overflow 32 bits quickly
		add_arith(ooo_pkg::OP_MUL, 5'd16, 5'd1, 5'd2, rand_gap());
		add_arith(ooo_pkg::OP_MUL, 5'd17, 5'd16, 5'd16, rand_gap());
		add_arith(ooo_pkg::OP_MUL, 5'd18, 5'd17, 5'd3, rand_gap());
		add_arith(ooo_pkg::OP_MUL, 5'd19, 5'd18, 5'd18, rand_gap());
		add_addi(5'd20, 5'd19, 12'(xorshift_next()), rand_gap());
		// mul then independent add then the add that needs both
		for (int k = 0; k < 3; k++) begin
			add_arith(ooo_pkg::OP_MUL, 5'd21, pick_reg(1, 20), pick_reg(1, 20), rand_gap());
			// no gap so this add finishes ahead of the mul
			add_arith(ooo_pkg::OP_ADD, 5'd22, pick_reg(1, 20), pick_reg(1, 20), 4'd0);
			add_arith(ooo_pkg::OP_ADD, 5'd23, 5'd21, 5'd22, rand_gap());
		end
		// back-to-back chained muls outnumbering the buffer slots
		burst_lo = n_entries;
		for (int k = 0; k < 12; k++) begin
			src = (k == 0) ? pick_reg(1, 20) : 5'(24 + (k - 1) % 8);
			add_arith(ooo_pkg::OP_MUL, 5'(24 + k % 8), src, pick_reg(1, 23), 4'd0);
		end
		burst_hi = n_entries - 1;
		// x0 as destination and as source
		add_arith(ooo_pkg::OP_ADD, 5'd0, 5'd1, 5'd2, rand_gap());
		add_addi(5'd0, 5'd3, 12'(xorshift_next()), rand_gap());
		add_arith(ooo_pkg::OP_ADD, 5'd5, 5'd0, 5'd4, rand_gap());
		// lui and and are both unsupported
		w = {20'h12345, 5'd7, 7'b0110111};
		push_entry(w, rand_gap(), 5'd7, 32'd0, 1'b0);
		w = enc_r(7'b0000000, 5'd8, 5'd1, 5'd2);
		w.r.funct3 = 3'b111;
		push_entry(w, rand_gap(), 5'd8, 32'd0, 1'b0);
		add_addi(5'd9, 5'd7, 12'd1, rand_gap());
		add_arith(ooo_pkg::OP_SUB, 5'd10, 5'd8, 5'd0, rand_gap());
		push_entry(ooo_pkg::WFI_WORD, rand_gap(), 5'd0, 32'd0, 1'b0);
		n_commits = n_entries;
		// offered after the halt and never committed
		add_addi(5'd1, 5'd1, 12'd1, 4'd0);
		add_arith(ooo_pkg::OP_MUL, 5'd2, 5'd2, 5'd2, 4'd0);
	endtask

	//////////////////////////////////////////////////
	// checks

	task automatic abort_run(input string msg);
		$display("%s", msg);
		$display("TEST FAIL");
		$fatal(1, "simulation stopped");
	endtask

	task automatic check_commit(input ooo_pkg::retire_s got, input logic [31:0] got_npc);
		ooo_pkg::retire_s exp;
		logic [31:0] exp_npc;
		exp = tab[commit_count].exp;
		exp_npc = 32'(4 * (commit_count + 1));
		if (got.wr_en !== exp.wr_en)
			abort_run($sformatf("error at %0t ns: commit %0d wr_en %b, expected %b",
				$time, commit_count, got.wr_en, exp.wr_en));
		else if (exp.wr_en && (got.rd !== exp.rd || got.value !== exp.value))
			abort_run($sformatf("error at %0t ns: commit %0d x%0d = %h, expected x%0d = %h",
				$time, commit_count, got.rd, got.value, exp.rd, exp.value));
		else if (got_npc !== exp_npc)
			abort_run($sformatf("error at %0t ns: commit %0d npc %h, expected %h",
				$time, commit_count, got_npc, exp_npc));
	endtask

	task automatic check_halt(input logic exp_halted);
		if (halted !== exp_halted)
			abort_run($sformatf("error at %0t ns: halted is %b, expected %b",
				$time, halted, exp_halted));
		else if (exp_halted && stall !== 1'b1)
			abort_run($sformatf("error at %0t ns: stall low while halted", $time));
	endtask

	//////////////////////////////////////////////////
	// driver and commit monitor and timeout

	// runs from falling edge to falling edge and holds the word through stall
	task automatic drive_entry(input int idx);
		logic accepted;
		accepted = 1'b0;
		inst_valid = 1'b0;
		repeat (tab[idx].gap) @(negedge clock);
		inst = tab[idx].word;
		inst_valid = 1'b1;
		while (!accepted) begin
			#1;
			accepted = stall === 1'b0;
			if (stall === 1'b1 && idx >= burst_lo && idx <= burst_hi)
				saw_burst_stall = 1'b1;
			@(negedge clock);
		end
		inst_valid = 1'b0;
	endtask

	always @(negedge clock) begin : commit_monitor
		ooo_pkg::retire_s seen;
		seen.valid = commit_valid;
		seen.rd    = commit_rd;
		seen.wr_en = commit_wr_en;
		seen.value = commit_data;
		if (commit_valid === 1'b1) begin
			if (commit_count >= n_commits)
				abort_run("a commit arrived after the last expected one");
			else
				check_commit(seen, commit_npc);
			commit_count++;
		end
	end

	always @(posedge clock) begin
		cycle_count = cycle_count + 1;
		if (cycle_count > CYCLE_LIMIT)
			abort_run($sformatf("run did not finish within %0d cycles", CYCLE_LIMIT));
	end

	initial begin
		inst_valid = 1'b0;
		inst = '0;
		rng = SEED;
		build_table();
		@(negedge reset);
		@(negedge clock);
		if (stall !== 1'b0 || commit_valid !== 1'b0)
			abort_run("stall or commit_valid high right after reset");
		check_halt(1'b0);
		for (int i = 0; i < n_commits; i++)
			drive_entry(i);
		if (!saw_burst_stall)
			abort_run("stall never rose during the mul burst");
		while (halted !== 1'b1)
			@(negedge clock);
		// source keeps offering words that the core must ignore
		for (int i = n_commits; i < n_entries; i++) begin
			inst = tab[i].word;
			inst_valid = 1'b1;
			repeat (HOLD_CYCLES) begin
				@(negedge clock);
				check_halt(1'b1);
			end
		end
		inst_valid = 1'b0;
		if (commit_count == n_commits) begin
			$display("TEST PASS");
			$finish;
		end else begin
			abort_run($sformatf("only %0d of %0d expected commits seen",
				commit_count, n_commits));
		end
	end

endmodule

`default_nettype wire

//--- ooo_core.f
hw/ooo_pkg.sv
hw/issue_stage.sv
hw/execute_unit.sv
hw/reorder_buffer.sv
hw/commit_stage.sv
hw/ooo_core.sv
testbench/tb_clock_gen.sv
testbench/ooo_core_sva.sv
testbench/ooo_core_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# compile with Verilator, run, and look for the pass line in the output
set -o pipefail
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -j 0 --top-module ooo_core_tb \
	-f ooo_core.f -o ooo_core_sim \
	&& ./obj_dir/ooo_core_sim | tee /dev/stderr | grep -x "TEST PASS" > /dev/null \
	&& echo "simulation passed" \
	|| { echo "simulation failed"; exit 1; }
